//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_board_top
FILELIST  ?= board.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard src/*.sv include/*.svh verif/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- board.f
+incdir+include
src/board_pkg.sv
src/tm1638_board_controller.sv
src/inmp441_mic_i2s_receiver.sv
src/i2s_audio_out.sv
src/lab_top.sv
src/board_specific_top.sv
verif/tb_board_top.sv

//--- include/pin_map.svh
`ifndef PIN_MAP_SVH
`define PIN_MAP_SVH

// TM1638 module, GPIO_0
`define PIN_TM_STB     27  // JP1 pin 32
`define PIN_TM_CLK     29  // JP1 pin 34
`define PIN_TM_DIO     31  // JP1 pin 36

// INMP441 microphone, GPIO_0
`define PIN_MIC_LR     0   // JP1 pin 1
`define PIN_MIC_GND    1   // Supply return
`define PIN_MIC_WS     2   // JP1 pin 3
`define PIN_MIC_VCC    3   // 3.3 V supply
`define PIN_MIC_SCK    4   // JP1 pin 5
`define PIN_MIC_SD     5   // JP1 pin 6

// I2S DAC, GPIO_0
`define PIN_AUD_LRCLK  11  // JP1 pin 14
`define PIN_AUD_SDATA  13  // JP1 pin 16
`define PIN_AUD_BCLK   15  // JP1 pin 18
`define PIN_AUD_MCLK   17  // JP1 pin 20

`endif

//--- src/board_pkg.sv
`default_nettype none

package board_pkg;

    // ------------------------------
    // Sample and display widths
    // ------------------------------

    localparam int w_mic      = 24;  // INMP441 word
    localparam int w_sound    = 16;  // DAC word
    localparam int w_tm_key   = 8;
    localparam int w_tm_led   = 8;
    localparam int w_tm_digit = 8;

    // ------------------------------
    // TM1638 command bytes
    // ------------------------------

    localparam logic [7:0] tm_cmd_write_auto = 8'h40;  // Data write, auto increment
    localparam logic [7:0] tm_cmd_read_keys  = 8'h42;  // Key scan read
    localparam logic [7:0] tm_cmd_addr0      = 8'hc0;  // Address 0
    localparam logic [7:0] tm_cmd_display_on = 8'h8a;  // Display on, brightness 2

    // Hex nibble to abcdefgh, segment a in bit 7, dot clear
    localparam logic [7:0] seg_hex [16] = '{
        8'hfc, 8'h60, 8'hda, 8'hf2,  // 0 1 2 3
        8'h66, 8'hb6, 8'hbe, 8'he0,  // 4 5 6 7
        8'hfe, 8'hf6, 8'hee, 8'h3e,  // 8 9 A b
        8'h9c, 8'h7a, 8'h9e, 8'h8e   // C d E F
    };

endpackage

`default_nettype wire

//--- src/board_specific_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pin_map.svh"

module board_specific_top
#(
    parameter clk_mhz = 50,
              w_key   = 2,
              w_sw    = 4,
              w_led   = 8,
              w_gpio  = 36
)
(
    input  wire                 FPGA_CLK1_50,
    input  wire  [w_key - 1:0]  KEY,     // Active low
    input  wire  [w_sw - 1:0]   SW,
    output logic [w_led - 1:0]  LED,
    inout  wire  [w_gpio - 1:0] GPIO_0,
    inout  wire  [w_gpio - 1:0] GPIO_1
);

    localparam int w_lab_sw = w_sw - 1;  // Top switch is reset

    wire clk = FPGA_CLK1_50;
    wire rst = SW[w_lab_sw];

    logic [board_pkg::w_tm_key - 1:0]   tm_key;
    logic [board_pkg::w_tm_key - 1:0]   lab_key;
    logic [board_pkg::w_tm_led - 1:0]   lab_led;
    logic [board_pkg::w_tm_digit - 1:0] lab_digit;
    logic [7:0]                         abcdefgh;
    logic [7:0]                         hgfedcba;
    logic [board_pkg::w_mic - 1:0]      mic;
    logic [board_pkg::w_sound - 1:0]    sound;

    // ------------------------------
    // Key merge and display order
    // ------------------------------

    always_comb
    begin
        lab_key              = tm_key;
        lab_key[w_key - 1:0] = tm_key[w_key - 1:0] | ~KEY;  // Same key from either source
    end

    assign LED      = lab_led[w_led - 1:0];
    assign hgfedcba = {<<{abcdefgh}};                       // TM1638 wants segment a in bit 0

    lab_top
    #(
        .w_key    ( board_pkg::w_tm_key ),
        .w_sw     ( w_lab_sw            ),
        .w_led    ( board_pkg::w_tm_led )
    )
    i_lab_top
    (
        .clk      ( clk                 ),
        .rst      ( rst                 ),
        .key      ( lab_key             ),
        .sw       ( SW[w_lab_sw - 1:0]  ),
        .led      ( lab_led             ),
        .abcdefgh ( abcdefgh            ),
        .digit    ( lab_digit           ),
        .mic      ( mic                 ),
        .sound    ( sound               )
    );

    // ------------------------------
    // Peripherals on GPIO_0
    // ------------------------------

    tm1638_board_controller #( .clk_mhz ( clk_mhz ) ) i_tm1638
    (
        .clk      ( clk                   ),
        .rst      ( rst                   ),
        .hgfedcba ( hgfedcba              ),
        .digit    ( lab_digit             ),
        .ledr     ( lab_led               ),
        .keys     ( tm_key                ),
        .sio_stb  ( GPIO_0[`PIN_TM_STB]   ),
        .sio_clk  ( GPIO_0[`PIN_TM_CLK]   ),
        .sio_data ( GPIO_0[`PIN_TM_DIO]   )
    );

    inmp441_mic_i2s_receiver #( .clk_mhz ( clk_mhz ) ) i_mic
    (
        .clk      ( clk                   ),
        .rst      ( rst                   ),
        .lr       ( GPIO_0[`PIN_MIC_LR]   ),
        .ws       ( GPIO_0[`PIN_MIC_WS]   ),
        .sck      ( GPIO_0[`PIN_MIC_SCK]  ),
        .sd       ( GPIO_0[`PIN_MIC_SD]   ),
        .value    ( mic                   )
    );

    assign GPIO_0[`PIN_MIC_GND] = 1'b0;  // Mic powered from header pins
    assign GPIO_0[`PIN_MIC_VCC] = 1'b1;

    i2s_audio_out #( .clk_mhz ( clk_mhz ) ) i_audio
    (
        .clk      ( clk                   ),
        .rst      ( rst                   ),
        .data_in  ( sound                 ),
        .mclk     ( GPIO_0[`PIN_AUD_MCLK] ),
        .bclk     ( GPIO_0[`PIN_AUD_BCLK] ),
        .lrclk    ( GPIO_0[`PIN_AUD_LRCLK]),
        .sdata    ( GPIO_0[`PIN_AUD_SDATA])
    );

    assign GPIO_1 = 'z;                  // Second header unused, floating

endmodule

`default_nettype wire

//--- src/i2s_audio_out.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_audio_out
#(
    parameter clk_mhz = 50
)
(
    input  wire                             clk,
    input  wire                             rst,
    input  wire  [board_pkg::w_sound - 1:0] data_in,
    output logic                            mclk,
    output logic                            bclk,
    output logic                            lrclk,
    output logic                            sdata
);

    localparam int w_mclk_div = $clog2(clk_mhz) - 4;  // clk / 4
    localparam int w_bclk_div = w_mclk_div + 3;       // clk / 32
    localparam int w_cnt      = w_bclk_div + 5;       // 16 bclk per channel

    logic [w_cnt - 1:0]              cnt;
    logic                            bclk_fall;
    logic                            lr_flip;
    logic [board_pkg::w_sound - 1:0] word;            // Sample for both channels
    logic [board_pkg::w_sound - 1:0] shreg;

    // All clocks from one counter, so edges line up
    assign mclk      = cnt[w_mclk_div - 1];
    assign bclk      = cnt[w_bclk_div - 1];
    assign lrclk     = cnt[w_cnt - 1];
    assign bclk_fall = &cnt[w_bclk_div - 1:0];
    assign lr_flip   = &cnt[w_cnt - 2:0];             // Also a falling bclk

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt   <= '0;
            word  <= '0;
            shreg <= '0;
            sdata <= 1'b0;
        end
        else
        begin
            cnt <= cnt + 1'b1;
            if (lr_flip && lrclk)
                word <= data_in;                      // lrclk falling, new left word
            if (bclk_fall)
            begin
                sdata <= shreg[board_pkg::w_sound - 1];  // Last LSB on lrclk edge
                if (lr_flip)
                    shreg <= lrclk ? data_in : word;
                else
                    shreg <= shreg << 1;
            end
        end
    end

    a_lrclk_on_bclk_fall: assert property (@(posedge clk) disable iff (rst)
        $changed(lrclk) |-> $fell(bclk))
        else $error("lrclk changed off a falling bclk");

endmodule

`default_nettype wire

//--- src/inmp441_mic_i2s_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module inmp441_mic_i2s_receiver
#(
    parameter clk_mhz = 50
)
(
    input  wire                           clk,
    input  wire                           rst,
    output logic                          lr,
    output logic                          ws,
    output logic                          sck,
    input  wire                           sd,
    output logic [board_pkg::w_mic - 1:0] value
);

    localparam int w_sck_div = $clog2(clk_mhz) - 1;  // 32 clk per sck at 50 MHz
    localparam int w_cnt     = w_sck_div + 6;        // 32 sck per slot, two slots

    logic [w_cnt - 1:0]            cnt;
    logic [4:0]                    slot_bit;
    logic                          sck_rise;
    logic                          load;
    logic [board_pkg::w_mic - 1:0] shreg;

    assign lr       = 1'b0;                          // Mic answers in left slot
    assign sck      = cnt[w_sck_div - 1];
    assign ws       = cnt[w_cnt - 1];                // Low is left slot
    assign slot_bit = cnt[w_cnt - 2 -: 5];
    assign sck_rise = (cnt[w_sck_div - 1:0] == {1'b0, {(w_sck_div - 1){1'b1}}});

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    // Shifts every bit, holds the sample after bit 24
    always_ff @(posedge clk)
    begin
        if (sck_rise)
            shreg <= {shreg[board_pkg::w_mic - 2:0], sd};
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            load  <= 1'b0;
            value <= '0;
        end
        else
        begin
            load <= sck_rise && !ws && (slot_bit == 5'(board_pkg::w_mic));  // 25th edge
            if (load)
                value <= shreg;
        end
    end

    a_ws_on_low_sck: assert property (@(posedge clk) disable iff (rst) $changed(ws) |-> !sck)
        else $error("ws changed while sck high");

endmodule

`default_nettype wire

//--- src/lab_top.sv
`timescale 1ns/1ps
`default_nettype none

module lab_top
#(
    parameter w_key = 8,
              w_sw  = 3,
              w_led = 8
)
(
    input  wire                             clk,
    input  wire                             rst,
    input  wire  [w_key - 1:0]              key,
    input  wire  [w_sw - 1:0]               sw,
    output logic [w_led - 1:0]              led,
    output logic [7:0]                      abcdefgh,
    output logic [7:0]                      digit,
    input  wire  [board_pkg::w_mic - 1:0]   mic,
    output logic [board_pkg::w_sound - 1:0] sound
);

    logic [board_pkg::w_mic - 1:0] mag;
    logic [3:0]                    bar_len;
    logic [w_key - 1:0]            key_q;
    logic [31:0]                   presses;
    logic [10:0]                   scan;     // 256 clk per digit
    logic [2:0]                    scan_idx;

    // ------------------------------
    // Audio and level bar
    // ------------------------------

    assign mag = mic[board_pkg::w_mic - 1] ? -mic : mic;

    always_comb
    begin
        bar_len = '0;
        for (int i = 16; i < board_pkg::w_mic; i++)
            if (mag[i])
                bar_len = 4'(i - 15);  // Highest set bit wins
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sound <= '0;
            led   <= '0;
        end
        else
        begin
            sound <= $signed(mic[board_pkg::w_mic - 1 -: board_pkg::w_sound]) >>> sw;
            for (int i = 0; i < w_led; i++)
                led[i] <= (bar_len > i);     // Thermometer
        end
    end

    // ------------------------------
    // Key counter and digit scan
    // ------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            key_q   <= '0;
            presses <= '0;
            scan    <= '0;
        end
        else
        begin
            key_q <= key;
            if (|(key & ~key_q))
                presses <= presses + 1'b1;  // Any rising key
            scan <= scan + 1'b1;
        end
    end

    assign scan_idx = scan[10:8];
    assign digit    = 8'b1 << scan_idx;
    assign abcdefgh = board_pkg::seg_hex[presses[{scan_idx, 2'b00} +: 4]];  // Digit 0 low nibble

endmodule

`default_nettype wire

//--- src/tm1638_board_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tm1638_board_controller
#(
    parameter clk_mhz = 50
)
(
    input  wire                                clk,
    input  wire                                rst,
    input  wire  [7:0]                         hgfedcba,
    input  wire  [board_pkg::w_tm_digit - 1:0] digit,     // One-hot strobe
    input  wire  [board_pkg::w_tm_led - 1:0]   ledr,
    output logic [board_pkg::w_tm_key - 1:0]   keys,
    output logic                               sio_stb,
    output logic                               sio_clk,
    inout  wire                                sio_data
);

    localparam int half_cycles = clk_mhz;                // 1 us half period of sio_clk
    localparam int w_timer     = $clog2(half_cycles);

    localparam logic [1:0] st_gap = 2'd0,  // Strobe high between transactions
                           st_hi  = 2'd1,  // Strobe low, clock high
                           st_lo  = 2'd2;  // Clock low, data bit on the line

    logic [7:0]                       seg_buf [board_pkg::w_tm_digit];
    logic [w_timer - 1:0]             timer;
    logic                             tick;
    logic [1:0]                       state;
    logic [1:0]                       txn;        // 0 mode, 1 data, 2 display, 3 keys
    logic [4:0]                       byte_idx;
    logic [2:0]                       bit_idx;
    logic                             done;
    logic [4:0]                       last_byte;
    logic [4:0]                       addr;
    logic                             reading;
    logic [7:0]                       tx_byte;
    logic                             dio_out;
    logic                             dio_oe;
    logic [board_pkg::w_tm_key - 1:0] key_sh;

    // ------------------------------
    // Segment buffer
    // ------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < board_pkg::w_tm_digit; i++)
                seg_buf[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < board_pkg::w_tm_digit; i++)
                if (digit[i])
                    seg_buf[i] <= hgfedcba;  // Catch the scanned digit
        end
    end

    // ------------------------------
    // Bit timer and byte source
    // ------------------------------

    assign tick = (timer == w_timer'(half_cycles - 1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            timer <= '0;
        else
            timer <= tick ? '0 : timer + 1'b1;
    end

    assign addr    = byte_idx - 5'd1;                     // Display RAM address
    assign reading = (txn == 2'd3) && (byte_idx != '0);   // Input bytes of key scan

    always_comb
    begin
        last_byte = 5'd0;
        case (txn)
            2'd0: tx_byte = board_pkg::tm_cmd_write_auto;
            2'd1:
            begin
                last_byte = 5'd16;                        // Command plus 16 data bytes
                if (byte_idx == '0)
                    tx_byte = board_pkg::tm_cmd_addr0;
                else if (!addr[0])
                    tx_byte = seg_buf[addr[3:1]];         // Even address, segments
                else
                    tx_byte = {7'd0, ledr[addr[3:1]]};    // Odd address, LED in bit 0
            end
            2'd2: tx_byte = board_pkg::tm_cmd_display_on;
            default:
            begin
                last_byte = 5'd4;                         // Command plus 4 key bytes
                tx_byte   = board_pkg::tm_cmd_read_keys;
            end
        endcase
    end

    // ------------------------------
    // Frame FSM
    // ------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= st_gap;
            txn      <= '0;
            byte_idx <= '0;
            bit_idx  <= '0;
            done     <= 1'b0;
            sio_stb  <= 1'b1;
            sio_clk  <= 1'b1;
            dio_out  <= 1'b1;
            dio_oe   <= 1'b1;
            key_sh   <= '0;
            keys     <= '0;
        end
        else if (tick)
        begin
            case (state)
                st_gap:
                begin
                    sio_stb <= 1'b0;                      // Open transaction
                    state   <= st_hi;
                end
                st_lo:
                begin
                    sio_clk <= 1'b1;                      // Rising edge, both sides sample
                    if (reading && bit_idx[1:0] == 2'd0)
                        key_sh[{addr[1:0], bit_idx[2]}] <= sio_data;  // Bits 0 and 4
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7)
                    begin
                        if (byte_idx == last_byte)
                            done <= 1'b1;
                        else
                            byte_idx <= byte_idx + 1'b1;
                    end
                    state <= st_hi;
                end
                default:
                begin
                    if (done)
                    begin
                        sio_stb  <= 1'b1;                 // Close transaction
                        dio_out  <= 1'b1;
                        dio_oe   <= 1'b1;                 // Take line back after reads
                        done     <= 1'b0;
                        byte_idx <= '0;
                        txn      <= txn + 1'b1;           // Wraps into next frame
                        if (txn == 2'd3)
                            keys <= key_sh;
                        state <= st_gap;
                    end
                    else
                    begin
                        sio_clk <= 1'b0;
                        dio_out <= tx_byte[bit_idx];      // LSB first
                        dio_oe  <= !reading;
                        state   <= st_lo;
                    end
                end
            endcase
        end
    end

    assign sio_data = dio_oe ? dio_out : 1'bz;

    a_clk_idle: assert property (@(posedge clk) disable iff (rst) sio_stb |-> sio_clk)
        else $error("sio_clk low outside a strobed transaction");

    a_read_released: assert property (@(posedge clk) disable iff (rst)
        (state == st_lo && reading) |-> !dio_oe)
        else $error("sio_data driven during key read");

endmodule

`default_nettype wire

//--- verif/tb_board_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pin_map.svh"

module tb_board_top;

    logic        clk;
    logic [1:0]  key_n;                 // Onboard keys are active low
    logic [3:0]  sw;
    wire  [7:0]  led;
    wire  [35:0] gpio0;
    wire  [35:0] gpio1;

    logic [23:0] mic_word;              // Word the mic model sends
    logic        mic_sd;
    logic [7:0]  tm_keys;               // Keys the TM1638 model reports
    logic        tm_dio_drv;
    logic [7:0]  tm_ram [16];           // Display RAM seen by the model
    int          frame_cnt;
    int          press_cnt;             // Expected key count

    wire ws    = gpio0[`PIN_MIC_WS];
    wire sck   = gpio0[`PIN_MIC_SCK];
    wire bclk  = gpio0[`PIN_AUD_BCLK];
    wire lrclk = gpio0[`PIN_AUD_LRCLK];
    wire sdata = gpio0[`PIN_AUD_SDATA];
    wire stb   = gpio0[`PIN_TM_STB];
    wire sclk  = gpio0[`PIN_TM_CLK];
    wire dio   = gpio0[`PIN_TM_DIO];

    assign gpio0[`PIN_MIC_SD] = mic_sd;
    assign gpio0[`PIN_TM_DIO] = tm_dio_drv;   // Released to z outside key reads

    board_specific_top UUT
    (
        .FPGA_CLK1_50 ( clk   ),
        .KEY          ( key_n ),
        .SW           ( sw    ),
        .LED          ( led   ),
        .GPIO_0       ( gpio0 ),
        .GPIO_1       ( gpio1 )
    );

    always #10 clk = ~clk;             // 50 MHz

    // ------------------------------
    // Microphone model
    // ------------------------------

    logic prev_sck;
    logic prev_ws;
    int   mic_k;                        // sck falls since slot start

    always @(posedge clk)
    begin
        #2;
        if (prev_sck === 1'b1 && sck === 1'b0)
        begin
            mic_k = (ws !== prev_ws) ? 0 : mic_k + 1;  // ws moves with a sck fall
            mic_sd = (!ws && mic_k >= 1 && mic_k <= 24) ? mic_word[24 - mic_k] : 1'b0;
        end
        prev_sck = sck;
        prev_ws  = ws;
    end

    // ------------------------------
    // TM1638 model
    // ------------------------------

    logic       prev_sclk;
    logic       in_txn;
    logic       reading;
    logic [7:0] tm_cmd;
    logic [7:0] rx;
    logic [3:0] tm_addr;
    int         bitcnt;
    int         bytecnt;

    always @(posedge clk)
    begin
        #2;
        if (stb === 1'b1)
        begin
            if (in_txn && tm_cmd == board_pkg::tm_cmd_read_keys)
                frame_cnt++;            // Key read closes a frame
            in_txn     = 1'b0;
            reading    = 1'b0;
            tm_dio_drv = 1'bz;
        end
        else if (stb === 1'b0)
        begin
            if (!in_txn)
            begin
                in_txn  = 1'b1;
                bitcnt  = 0;
                bytecnt = 0;
                tm_cmd  = '0;
            end
            if (prev_sclk === 1'b0 && sclk === 1'b1)
            begin
                rx[bitcnt] = dio;       // LSB first
                bitcnt++;
                if (bitcnt == 8)
                begin
                    bitcnt = 0;
                    if (bytecnt == 0)
                    begin
                        tm_cmd  = rx;
                        reading = (rx == board_pkg::tm_cmd_read_keys);
                        if (rx[7:6] == 2'b11)
                            tm_addr = rx[3:0];
                    end
                    else if (!reading && tm_cmd[7:6] == 2'b11)
                    begin
                        tm_ram[tm_addr] = rx;
                        tm_addr++;
                    end
                    bytecnt++;
                    if (reading && bytecnt == 5)
                        tm_dio_drv = 1'bz;     // Last key bit taken
                end
            end
            else if (prev_sclk === 1'b1 && sclk === 1'b0 && reading && bytecnt >= 1)
            begin
                if (bitcnt == 0)
                    tm_dio_drv = tm_keys[2 * (bytecnt - 1)];
                else if (bitcnt == 4)
                    tm_dio_drv = tm_keys[2 * (bytecnt - 1) + 1];
                else
                    tm_dio_drv = 1'b0;
            end
        end
        prev_sclk = sclk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    task automatic step;
        @(posedge clk);
        #2;                             // Inputs change after outputs settle
    endtask

    task automatic timeout_abort(input string what);
        $display("SOME TESTS FAILED");
        $fatal(1, "Timeout while waiting for %s", what);
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic wait_ws_rise;
        int   n;
        logic prev;
        logic hit;
        n    = 0;
        prev = ws;
        do
        begin
            step();
            n++;
            if (n > 5000)
                timeout_abort("microphone ws rise");
            hit  = !prev && ws;
            prev = ws;
        end while (!hit);
    endtask

    // Waits for lrclk fall, then takes delay bit plus 16 bits on rising bclk
    task automatic capture_dac(output logic [15:0] word);
        int   n;
        logic prev;
        logic hit;
        n    = 0;
        prev = lrclk;
        do
        begin
            step();
            n++;
            if (n > 3000)
                timeout_abort("audio lrclk fall");
            hit  = prev && !lrclk;
            prev = lrclk;
        end while (!hit);
        for (int k = 0; k <= 16; k++)
        begin
            n    = 0;
            prev = bclk;
            do
            begin
                step();
                n++;
                if (n > 100)
                    timeout_abort("audio bclk rise");
                hit  = !prev && bclk;
                prev = bclk;
            end while (!hit);
            if (k >= 1)
                word[16 - k] = sdata;   // MSB first
        end
    endtask

    task automatic wait_frames(input int count);
        int n;
        int target;
        n      = 0;
        target = frame_cnt + count;
        while (frame_cnt < target)
        begin
            step();
            n++;
            if (n > 30000 * count)
                timeout_abort("TM1638 refresh frame");
        end
    endtask

    // Thermometer bar from the sample magnitude
    function automatic logic [7:0] bar_rule(input logic [23:0] s);
        logic [23:0] mag;
        int          pos;
        int          len;
        mag = s[23] ? -s : s;
        pos = -1;
        for (int i = 0; i < 24; i++)
            if (mag[i])
                pos = i;
        len = pos - 15;
        if (len < 0)
            len = 0;
        if (len > 8)
            len = 8;
        return 8'((16'd1 << len) - 1);
    endfunction

    function automatic int decode_digit(input logic [7:0] hgfedcba);
        logic [7:0] abcdefgh;
        int         found;
        abcdefgh = {<<{hgfedcba}};
        found    = -1;
        for (int i = 0; i < 16; i++)
            if (board_pkg::seg_hex[i] == abcdefgh)
                found = i;
        return found;
    endfunction

    task automatic set_sample(input logic [23:0] s);
        mic_word = s;
        wait_ws_rise();                 // Slot in flight may be mixed
        wait_ws_rise();                 // One clean left slot captured
    endtask

    task automatic check_digits;
        for (int d = 0; d < 8; d++)
            check_equal($sformatf("tm digit %0d", d), decode_digit(tm_ram[2 * d]),
                        (press_cnt >> (4 * d)) & 32'hf);
    endtask

    // ------------------------------
    // Tests
    // ------------------------------

    task automatic test_reset_state;
        check_equal("mclk", gpio0[`PIN_AUD_MCLK], 0);
        check_equal("bclk", bclk, 0);
        check_equal("lrclk", lrclk, 0);
        check_equal("sdata", sdata, 0);
        check_equal("sio_stb", stb, 1);
        check_equal("sio_clk", sclk, 1);
        check_equal("sio_data", dio, 1);
        check_equal("mic lr", gpio0[`PIN_MIC_LR], 0);
        check_equal("mic gnd", gpio0[`PIN_MIC_GND], 0);
        check_equal("mic vcc", gpio0[`PIN_MIC_VCC], 1);
        check_equal("LED", led, 0);
    endtask

    task automatic test_audio_path;
        logic [15:0] word;
        logic [15:0] exp;
        logic [23:0] sample;
        for (int sh = 0; sh < 4; sh++)
        begin
            sw[2:0]    = 3'(sh);
            sample     = 24'($urandom);
            sample[23] = sh[0];         // Odd shifts get a negative sample
            set_sample(sample);
            for (int b = 0; b < 16; b++)
                exp[b] = (b + sh < 16) ? sample[8 + b + sh] : sample[23];  // Sign fill
            capture_dac(word);
            check_equal("dac word", word, exp);
        end
        sw[2:0] = 3'd0;
    endtask

    task automatic test_level_bar;
        logic [23:0] samples [7];
        samples = '{24'h000100, 24'h010000, 24'h030000, 24'hff0000,
                    24'h7fffff, 24'h800000, 24'hfffff0};
        foreach (samples[i])
        begin
            set_sample(samples[i]);
            check_equal("LED", led, bar_rule(samples[i]));
        end
    endtask

    task automatic test_tm_leds;
        logic [7:0] bits;
        set_sample(24'h0c1234);         // Four LEDs lit
        wait_frames(2);
        for (int i = 0; i < 8; i++)
            bits[i] = tm_ram[2 * i + 1][0];
        check_equal("tm leds", bits, bar_rule(mic_word));
    endtask

    task automatic test_key_count;
        for (int i = 0; i < 3; i++)
        begin
            key_n[1] = 1'b0;
            repeat (20) step();
            key_n[1] = 1'b1;
            repeat (20) step();
            press_cnt++;
        end
        for (int i = 0; i < 2; i++)
        begin
            tm_keys[5] = 1'b1;          // Held across a key scan
            wait_frames(2);
            tm_keys[5] = 1'b0;
            wait_frames(2);
            press_cnt++;
        end
        wait_frames(2);
        check_digits();
    endtask

    task automatic test_key_merge;
        key_n[0]   = 1'b0;
        tm_keys[0] = 1'b1;              // Same key from both sources
        wait_frames(2);
        key_n[0]   = 1'b1;
        tm_keys[0] = 1'b0;
        wait_frames(2);
        press_cnt++;
        wait_frames(2);
        check_digits();
    endtask

    initial
    begin
        void'($urandom(32620));
        clk        = 1'b0;
        key_n      = 2'b11;
        sw         = 4'b1000;           // Top switch is reset
        mic_word   = '0;
        mic_sd     = 1'b0;
        tm_keys    = '0;
        tm_dio_drv = 1'bz;
        frame_cnt  = 0;
        press_cnt  = 0;
        in_txn     = 1'b0;
        reading    = 1'b0;
        mic_k      = 0;
        for (int i = 0; i < 16; i++)
            tm_ram[i] = '0;
        repeat (8) step();
        test_reset_state();
        repeat (8) step();
        sw[3] = 1'b0;
        test_audio_path();
        test_level_bar();
        test_tm_leds();
        test_key_count();
        test_key_merge();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
